/* verilog/rv_isa_pkg.sv */
// rv32 instruction-set view: widths, major opcodes and the words the front end recognizes
`default_nettype none

package rv_isa_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // basic widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int xlen = 32;          // data and address width

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // major opcodes, bits [6:0] of the word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // only the two that redirect are listed
    // branches and jalr fall through as plain words
    typedef enum logic [6:0] {
        opcode_jal    = 7'b110_1111,   // jump and link
        opcode_system = 7'b111_0011    // ecall, ebreak, csr ops, xret
    } opcode_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // full system encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // funct12 | rs1 | funct3 | rd | opcode
    localparam logic [xlen-1:0] ecall_word = {
        12'h000, 5'd0, 3'b000, 5'd0, opcode_system
    };                                 // 32'h0000_0073

    localparam logic [xlen-1:0] mret_word = {
        12'h302, 5'd0, 3'b000, 5'd0, opcode_system
    };                                 // 32'h3020_0073

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode classes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        cls_other,                     // retires, no redirect
        cls_jal,                       // pc relative jump
        cls_ecall,                     // trap to mtvec
        cls_mret                       // return to mepc
    } instr_class_e;

endpackage

`default_nettype wire

/* verilog/fe_cfg_pkg.sv */
// front-end configuration: reset pc, instruction memory size, path tag width, trap vector reset
`default_nettype none

package fe_cfg_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // program counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [31:0] start_address = 32'h0000_0000;   // pc after reset

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction memory
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int imem_words  = 256;  // 1 KiB of code
    localparam int imem_addr_w = 8;    // word index bits, log2(imem_words)

    // path tag, bumped on every redirect
    // 3 bits is plenty since at most one redirect is in flight
    localparam int tag_w = 3;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // trap
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [31:0] mtvec_reset = 32'h0000_0300;     // word 192

endpackage

`default_nettype wire

/* verilog/fetch.sv */
// fetch unit: program counter with priority redirect and the path tag calculator
`timescale 1ns/1ps
`default_nettype none

module fetch (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         stall_i,             // freeze the stage
    input  logic                         jump_i,
    input  logic [rv_isa_pkg::xlen-1:0]  jump_target_i,
    input  logic                         exception_raised_i,  // ecall
    input  logic                         interrupt_ack_i,
    input  logic                         machine_return_i,    // mret
    input  logic [rv_isa_pkg::xlen-1:0]  mtvec_i,
    input  logic [rv_isa_pkg::xlen-1:0]  mepc_i,
    output logic [rv_isa_pkg::xlen-1:0]  instruction_address_o,
    output logic [rv_isa_pkg::xlen-1:0]  pc_o,
    output logic [fe_cfg_pkg::tag_w-1:0] tag_o
);
    import rv_isa_pkg::*;
    import fe_cfg_pkg::*;

    logic [xlen-1:0]  pc;              // address being fetched
    logic [xlen-1:0]  pc_plus4;
    logic [tag_w-1:0] current_tag;     // tag carried by the word at decode
    logic [tag_w-1:0] next_tag;        // tag of the path after a redirect
    logic             redirect;
    logic             advance;

    assign redirect = jump_i | exception_raised_i | interrupt_ack_i | machine_return_i;
    assign advance  = ~stall_i;
    assign pc_plus4 = pc + 32'd4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pc, priority order mret > trap > jump > +4
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= start_address;
        end else if (machine_return_i) begin
            pc <= mepc_i;              // resume point
        end else if (exception_raised_i || interrupt_ack_i) begin
            pc <= mtvec_i;             // enter handler
        end else if (jump_i) begin
            pc <= jump_target_i;
        end else if (advance) begin
            pc <= pc_plus4;
        end
    end

    // pc of the word that the memory returns next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_o <= start_address;
        end else if (advance) begin
            pc_o <= pc;
        end
    end

    // while stalled the memory reads the address already at decode again,
    // otherwise its output would run one word ahead of pc_o
    assign instruction_address_o = stall_i ? pc_o : pc;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // path tag
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next_tag moves at the redirect edge, current_tag one
    // non-stalled edge later, so the word fetched under the old pc
    // still leaves with the old tag and gets squashed
    always_ff @(posedge clk) begin
        if (reset) begin
            current_tag <= '0;
            next_tag    <= '0;
        end else if (redirect) begin
            next_tag <= current_tag + 1'b1;    // wraps
        end else if (advance) begin
            current_tag <= next_tag;
        end
    end

    assign tag_o = current_tag;

endmodule

`default_nettype wire

/* verilog/instr_mem.sv */
// instruction memory: word array with a registered read port and a load port
`timescale 1ns/1ps
`default_nettype none

module instr_mem (
    input  logic                               clk,
    input  logic [rv_isa_pkg::xlen-1:0]        addr_i,    // byte address
    output logic [rv_isa_pkg::xlen-1:0]        rdata_o,   // valid one cycle later
    input  logic                               we_i,      // load strobe
    input  logic [fe_cfg_pkg::imem_addr_w-1:0] waddr_i,   // word index
    input  logic [rv_isa_pkg::xlen-1:0]        wdata_i
);
    import rv_isa_pkg::*;
    import fe_cfg_pkg::*;

    logic [xlen-1:0]        mem [imem_words];
    logic [imem_addr_w-1:0] raddr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // drop the byte offset, upper bits alias
    assign raddr = addr_i[imem_addr_w+1:2];

    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr];         // reads every cycle
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // load side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // old data on a same-address read
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

endmodule

`default_nettype wire

/* verilog/trap_csr.sv */
// trap state: mtvec, mepc and the interrupt enable, updated on traps and returns
`timescale 1ns/1ps
`default_nettype none

module trap_csr (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        mtvec_we_i,       // host write
    input  logic [rv_isa_pkg::xlen-1:0] mtvec_wdata_i,
    input  logic                        ecall_i,          // pulse from decode
    input  logic                        interrupt_ack_i,  // pulse from decode
    input  logic                        mret_i,           // pulse from decode
    input  logic [rv_isa_pkg::xlen-1:0] trap_pc_i,        // pc at decode
    output logic [rv_isa_pkg::xlen-1:0] mtvec_o,
    output logic [rv_isa_pkg::xlen-1:0] mepc_o,
    output logic                        irq_enable_o
);
    import rv_isa_pkg::*;
    import fe_cfg_pkg::*;

    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic            irq_enable;

    // trap vector, only the host writes it
    always_ff @(posedge clk) begin
        if (reset) begin
            mtvec <= mtvec_reset;
        end else if (mtvec_we_i) begin
            mtvec <= mtvec_wdata_i;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // resume point
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            mepc <= start_address;
        end else if (interrupt_ack_i) begin
            mepc <= trap_pc_i;                  // re-run the interrupted word
        end else if (ecall_i) begin
            mepc <= trap_pc_i + 32'd4;          // skip the ecall
        end
    end

    // global enable, no nesting inside a handler
    always_ff @(posedge clk) begin
        if (reset) begin
            irq_enable <= 1'b1;
        end else if (ecall_i || interrupt_ack_i) begin
            irq_enable <= 1'b0;
        end else if (mret_i) begin
            irq_enable <= 1'b1;
        end
    end

    assign mtvec_o      = mtvec;
    assign mepc_o       = mepc;
    assign irq_enable_o = irq_enable;

endmodule

`default_nettype wire

/* verilog/decode_redirect.sv */
// decode and redirect: squashes stale-tag words, resolves jal/ecall/mret/irq, retires survivors
`timescale 1ns/1ps
`default_nettype none

module decode_redirect (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         stall_i,
    input  logic                         irq_i,            // level
    input  logic                         irq_enable_i,
    input  logic [rv_isa_pkg::xlen-1:0]  instr_i,          // memory read data
    input  logic [rv_isa_pkg::xlen-1:0]  pc_i,
    input  logic [fe_cfg_pkg::tag_w-1:0] tag_i,
    output logic                         jump_o,
    output logic [rv_isa_pkg::xlen-1:0]  jump_target_o,
    output logic                         exception_o,
    output logic                         interrupt_ack_o,
    output logic                         mret_o,
    output logic                         retire_valid_o,
    output logic [rv_isa_pkg::xlen-1:0]  retire_pc_o,
    output logic [rv_isa_pkg::xlen-1:0]  retire_instr_o
);
    import rv_isa_pkg::*;
    import fe_cfg_pkg::*;

    logic [tag_w-1:0] expected_tag;    // path decode is following
    logic             primed;          // fetch has delivered a first word
    logic             valid;           // word is on the right path, stage moving
    logic             irq_take;
    logic             redirect;
    instr_class_e     instr_class;
    logic [xlen-1:0]  j_imm;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // path check
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // right after reset the fetch registers still hold reset values,
    // the first real word shows up after one non-stalled edge
    always_ff @(posedge clk) begin
        if (reset) begin
            primed <= 1'b0;
        end else if (!stall_i) begin
            primed <= 1'b1;
        end
    end

    assign valid = primed && !stall_i && (tag_i == expected_tag);

    // stays in step with next_tag in fetch
    always_ff @(posedge clk) begin
        if (reset) begin
            expected_tag <= '0;
        end else if (redirect) begin
            expected_tag <= expected_tag + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // classify
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        instr_class = cls_other;
        case (instr_i[6:0])
            opcode_jal: begin
                instr_class = cls_jal;
            end
            opcode_system: begin
                // exact match, other system words are plain
                if (instr_i == ecall_word) begin
                    instr_class = cls_ecall;
                end else if (instr_i == mret_word) begin
                    instr_class = cls_mret;
                end
            end
            default: begin
                instr_class = cls_other;
            end
        endcase
    end

    // j-type immediate, imm[20|10:1|11|19:12]
    assign j_imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
    assign jump_target_o = pc_i + j_imm;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // redirect pulses
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign irq_take        = valid && irq_i && irq_enable_i;    // beats everything
    assign interrupt_ack_o = irq_take;
    assign jump_o          = valid && !irq_take && (instr_class == cls_jal);
    assign exception_o     = valid && !irq_take && (instr_class == cls_ecall);
    assign mret_o          = valid && !irq_take && (instr_class == cls_mret);
    assign redirect        = jump_o || exception_o || interrupt_ack_o || mret_o;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // retire
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // interrupted word is dropped, redirecting words still retire
    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid_o <= 1'b0;
        end else begin
            retire_valid_o <= valid && !irq_take;    // one-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (valid && !irq_take) begin
            retire_pc_o    <= pc_i;
            retire_instr_o <= instr_i;
        end
    end

endmodule

`default_nettype wire

/* verilog/frontend_top.sv */
// instruction front end top: fetch, instruction memory, trap state and decode/redirect
`timescale 1ns/1ps
`default_nettype none

module frontend_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               stall_i,
    input  logic                               irq_i,
    // memory load port
    input  logic                               imem_we_i,
    input  logic [fe_cfg_pkg::imem_addr_w-1:0] imem_waddr_i,
    input  logic [rv_isa_pkg::xlen-1:0]        imem_wdata_i,
    // trap vector write
    input  logic                               mtvec_we_i,
    input  logic [rv_isa_pkg::xlen-1:0]        mtvec_wdata_i,
    // retire report
    output logic                               retire_valid_o,
    output logic [rv_isa_pkg::xlen-1:0]        retire_pc_o,
    output logic [rv_isa_pkg::xlen-1:0]        retire_instr_o
);
    import rv_isa_pkg::*;
    import fe_cfg_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // internal nets
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [xlen-1:0]  imem_addr;
    logic [xlen-1:0]  imem_rdata;
    logic [xlen-1:0]  fetch_pc;        // also the trapping pc
    logic [tag_w-1:0] fetch_tag;
    logic             jump;
    logic [xlen-1:0]  jump_target;
    logic             exception;
    logic             interrupt_ack;
    logic             mret;
    logic [xlen-1:0]  mtvec;
    logic [xlen-1:0]  mepc;
    logic             irq_enable;

    fetch u_fetch (
        .clk                   (clk),
        .reset                 (reset),
        .stall_i               (stall_i),
        .jump_i                (jump),
        .jump_target_i         (jump_target),
        .exception_raised_i    (exception),
        .interrupt_ack_i       (interrupt_ack),
        .machine_return_i      (mret),
        .mtvec_i               (mtvec),
        .mepc_i                (mepc),
        .instruction_address_o (imem_addr),
        .pc_o                  (fetch_pc),
        .tag_o                 (fetch_tag)
    );

    instr_mem u_instr_mem (
        .clk     (clk),
        .addr_i  (imem_addr),
        .rdata_o (imem_rdata),
        .we_i    (imem_we_i),
        .waddr_i (imem_waddr_i),
        .wdata_i (imem_wdata_i)
    );

    trap_csr u_trap_csr (
        .clk             (clk),
        .reset           (reset),
        .mtvec_we_i      (mtvec_we_i),
        .mtvec_wdata_i   (mtvec_wdata_i),
        .ecall_i         (exception),
        .interrupt_ack_i (interrupt_ack),
        .mret_i          (mret),
        .trap_pc_i       (fetch_pc),
        .mtvec_o         (mtvec),
        .mepc_o          (mepc),
        .irq_enable_o    (irq_enable)
    );

    decode_redirect u_decode_redirect (
        .clk             (clk),
        .reset           (reset),
        .stall_i         (stall_i),
        .irq_i           (irq_i),
        .irq_enable_i    (irq_enable),
        .instr_i         (imem_rdata),
        .pc_i            (fetch_pc),
        .tag_i           (fetch_tag),
        .jump_o          (jump),
        .jump_target_o   (jump_target),
        .exception_o     (exception),
        .interrupt_ack_o (interrupt_ack),
        .mret_o          (mret),
        .retire_valid_o  (retire_valid_o),
        .retire_pc_o     (retire_pc_o),
        .retire_instr_o  (retire_instr_o)
    );

endmodule

`default_nettype wire

/* dv/frontend_assert.sv */
// bound checks on the decode stage: one-hot redirect pulses, quiet under stall, retire timing
`timescale 1ns/1ps
`default_nettype none

module frontend_assert (
    input logic clk,
    input logic reset,
    input logic stall_i,
    input logic jump_i,
    input logic exception_i,
    input logic interrupt_ack_i,
    input logic mret_i,
    input logic retire_valid_i
);
    int unsigned fail_count = 0;       // seen from the testbench
    logic [3:0]  pulses;

    assign pulses = {jump_i, exception_i, interrupt_ack_i, mret_i};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // redirect pulses
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    pulses_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(pulses))
        else begin
            fail_count++;
            $error("more than one redirect pulse in a cycle");
        end

    pulses_quiet_in_stall: assert property (
        @(posedge clk) disable iff (reset) stall_i |-> (pulses == 4'b0000)
    ) else begin
        fail_count++;
        $error("redirect pulse while stalled");
    end

    // retire strobe is registered, so it follows the stall by one edge
    retire_not_after_stall: assert property (
        @(posedge clk) disable iff (reset) stall_i |=> !retire_valid_i
    ) else begin
        fail_count++;
        $error("retire after a stalled edge");
    end

endmodule

bind decode_redirect frontend_assert redirect_checks (
    .clk             (clk),
    .reset           (reset),
    .stall_i         (stall_i),
    .jump_i          (jump_o),
    .exception_i     (exception_o),
    .interrupt_ack_i (interrupt_ack_o),
    .mret_i          (mret_o),
    .retire_valid_i  (retire_valid_o)
);

`default_nettype wire

/* dv/frontend_tb.sv */
// testbench for the instruction front end: random program, stalls and interrupts against a model
`timescale 1ns/1ps
`default_nettype none

module frontend_tb;
    import rv_isa_pkg::*;
    import fe_cfg_pkg::*;

    localparam int          n_retires         = 400;            // retires checked per run
    localparam int          reset_cycles      = 10;
    localparam int          main_words        = 100;            // main program, words 0..99
    localparam int          handler_len       = 6;              // plain words before the mret
    localparam logic [31:0] handler_base      = 32'h0000_0200;  // written into mtvec
    localparam int          handler_idx       = handler_base >> 2;
    localparam int          reset_handler_idx = mtvec_reset >> 2;  // handler before the write
    localparam int          cycle_limit       = 40 * n_retires + imem_words + reset_cycles;

    logic                   clk;
    logic                   reset;
    logic                   stall;
    logic                   irq;
    logic                   imem_we;
    logic [imem_addr_w-1:0] imem_waddr;
    logic [31:0]            imem_wdata;
    logic                   mtvec_we;
    logic [31:0]            mtvec_wdata;
    logic                   retire_valid;
    logic [31:0]            retire_pc;
    logic [31:0]            retire_instr;

    // program image and what the generator put at each word
    logic [31:0]  prog       [imem_words];
    instr_class_e word_class [imem_words];
    logic [31:0]  jal_target [imem_words];

    // model state
    logic [31:0] exp_pc;
    logic [31:0] resume_pc;                 // where the next mret lands
    logic [31:0] cur_mtvec;                 // trap vector as the design holds it
    logic        mtvec_moved;               // the host write has been issued
    logic        in_handler;
    logic        irq_seen;                  // irq high since the last retire
    logic        prev_stall;                // stall at the previous edge
    int unsigned retire_count;
    int unsigned cycle_count;
    int unsigned post_reset_cycles;

    frontend_top dut_i (
        .clk            (clk),
        .reset          (reset),
        .stall_i        (stall),
        .irq_i          (irq),
        .imem_we_i      (imem_we),
        .imem_waddr_i   (imem_waddr),
        .imem_wdata_i   (imem_wdata),
        .mtvec_we_i     (mtvec_we),
        .mtvec_wdata_i  (mtvec_wdata),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_instr_o (retire_instr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;             // 100 ns period
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic fail_run(input string what);
        $display("error at %0t ns: %s", $time, what);
        $display("TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "run stopped");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // program generator
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] plain_word();
        logic [31:0] w;
        w = $urandom;
        if (w[6:0] == opcode_jal) begin
            w[2] = 1'b0;                    // now some other major opcode
        end
        if (w == ecall_word || w == mret_word) begin
            w[8] = ~w[8];                   // still system, no longer an exact match
        end
        return w;
    endfunction

    // j-type layout imm[20|10:1|11|19:12], rd, opcode
    task automatic set_jal(input int from_idx, input int to_idx);
        logic [31:0] off;
        logic [4:0]  rd;
        off = 32'((to_idx - from_idx) * 4);
        rd  = 5'($urandom);
        prog[from_idx]       = {off[20], off[10:1], off[11], off[19:12], rd, opcode_jal};
        word_class[from_idx] = cls_jal;
        jal_target[from_idx] = 32'(to_idx * 4);
    endtask

    task automatic build_program();
        int r;
        int tgt;
        for (int i = 0; i < imem_words; i++) begin
            prog[i]       = plain_word();
            word_class[i] = cls_other;
            jal_target[i] = 32'd0;
        end
        for (int i = 0; i < main_words - 1; i++) begin
            r = $urandom % 100;
            if (r < 10) begin
                tgt = $urandom % main_words;
                if (tgt == i) begin
                    tgt = i + 1;            // no single-word loop
                end
                set_jal(i, tgt);
            end else if (r < 15) begin
                prog[i]       = ecall_word;
                word_class[i] = cls_ecall;
            end
        end
        set_jal(main_words - 1, 0);         // main program wraps around
        // one handler at each trap vector the run uses
        prog[handler_idx + handler_len]             = mret_word;
        word_class[handler_idx + handler_len]       = cls_mret;
        prog[reset_handler_idx + handler_len]       = mret_word;
        word_class[reset_handler_idx + handler_len] = cls_mret;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model, one call per retire
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic model_retire();
        logic [imem_addr_w-1:0] idx;
        // a taken interrupt shows up as a jump to the handler
        if (irq_seen && !in_handler && exp_pc != cur_mtvec && retire_pc == cur_mtvec) begin
            resume_pc  = exp_pc;            // skipped word runs again after mret
            in_handler = 1'b1;
            exp_pc     = cur_mtvec;
        end
        check_value(retire_pc, exp_pc, "retired pc");
        idx = exp_pc[imem_addr_w+1:2];
        check_value(retire_instr, prog[idx], "retired instruction word");
        case (word_class[idx])
            cls_jal: begin
                exp_pc = jal_target[idx];
            end
            cls_ecall: begin
                resume_pc  = exp_pc + 32'd4;
                in_handler = 1'b1;
                exp_pc     = cur_mtvec;
            end
            cls_mret: begin
                exp_pc     = resume_pc;
                in_handler = 1'b0;
            end
            default: begin
                exp_pc = exp_pc + 32'd4;
            end
        endcase
        irq_seen = 1'b0;
        retire_count++;
    endtask

    // outputs and driven inputs are both settled at the falling edge
    always @(negedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            fail_run("timeout, the expected number of retires never arrived");
        end
        if (reset) begin
            check_value(32'(retire_valid), 32'd0, "retire_valid_o during reset");
        end else begin
            if (retire_valid) begin
                if (prev_stall) begin
                    fail_run("instruction retired right after a stalled edge");
                end
                if (retire_count == 0) begin
                    check_value(post_reset_cycles, 32'd2, "first retire latency");
                end
                model_retire();
            end
            if (irq && !in_handler) begin
                irq_seen = 1'b1;
            end
            if (mtvec_we) begin
                cur_mtvec = mtvec_wdata;    // new vector from the coming edge on
            end
            prev_stall = stall;
            post_reset_cycles++;
        end
        if (dut_i.u_decode_redirect.redirect_checks.fail_count != 0) begin
            fail_run("an assertion on the decode stage failed");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        void'($urandom(32'h0fcd28eb));
        reset             = 1'b1;
        stall             = 1'b0;
        irq               = 1'b0;
        imem_we           = 1'b0;
        imem_waddr        = '0;
        imem_wdata        = 32'd0;
        mtvec_we          = 1'b0;
        mtvec_wdata       = 32'd0;
        exp_pc            = start_address;
        resume_pc         = start_address;
        cur_mtvec         = mtvec_reset;
        mtvec_moved       = 1'b0;
        in_handler        = 1'b0;
        irq_seen          = 1'b0;
        prev_stall        = 1'b0;
        retire_count      = 0;
        cycle_count       = 0;
        post_reset_cycles = 0;
        build_program();
        // memory has no reset, loaded while the core is held
        for (int i = 0; i < imem_words; i++) begin
            @(posedge clk);
            #1;
            imem_we    = 1'b1;
            imem_waddr = imem_addr_w'(i);
            imem_wdata = prog[i];
        end
        @(posedge clk);
        #1;
        imem_we = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        // first two cycles after release stay unstalled
        @(posedge clk);
        while (retire_count < n_retires) begin
            @(posedge clk);
            #1;
            stall    = ($urandom % 100) < 30;
            irq      = ($urandom % 100) < 6;
            mtvec_we = 1'b0;
            // inside a handler no trap is in flight, so the vector can move
            if (!mtvec_moved && in_handler && retire_count >= n_retires / 4) begin
                mtvec_we    = 1'b1;
                mtvec_wdata = handler_base;
                mtvec_moved = 1'b1;
            end
        end
        if (dut_i.u_decode_redirect.redirect_checks.fail_count == 0 && mtvec_moved) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            if (!mtvec_moved) begin
                $display("the trap vector was never rewritten during the run");
            end else begin
                $display("assertion failures on the decode stage");
            end
            $display("TESTS FAILED");
            $fatal(1, "run stopped");
        end
    end

endmodule

`default_nettype wire

/* files.f */
verilog/rv_isa_pkg.sv
verilog/fe_cfg_pkg.sv
verilog/fetch.sv
verilog/instr_mem.sv
verilog/trap_csr.sv
verilog/decode_redirect.sv
verilog/frontend_top.sv
dv/frontend_assert.sv
dv/frontend_tb.sv
